// ==== eth_crc.sv ====
module eth_crc (
   input  logic              RX_CLK,
   input  logic              rx_rst,
   input  logic              start,
   input  logic              data_en,
   input  eth_rx_pkg::byte_t data_in,
   output eth_rx_pkg::crc_t  crc_value
);
   import eth_rx_pkg::*;

   // reflected form of 04C11DB7
   localparam crc_t crc_poly = 32'hEDB88320;

   crc_t crc_reg;
   crc_t crc_next;

   // one byte, lsb first
   always_comb begin
      crc_next = crc_reg ^ {24'h000000, data_in};
      for (int i = 0; i < 8; i++) begin
         if (crc_next[0]) begin
            crc_next = (crc_next >> 1) ^ crc_poly;
         end else begin
            crc_next = crc_next >> 1;
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_reg <= '1;
      end else if (start) begin
         crc_reg <= '1;
      end else if (data_en) begin
         crc_reg <= crc_next;
      end
   end

   // raw register without output inversion
   assign crc_value = crc_reg;

endmodule

// ==== eth_rx_buffer.sv ====
module eth_rx_buffer #(
   parameter int DEPTH_WORDS = 512
) (
   input  logic        RX_CLK,
   input  logic        wr_en,
   input  logic [10:0] wr_addr,
   input  logic [7:0]  wr_data,
   input  logic [8:0]  rd_addr,
   output logic [31:0] rd_data
);

   // byte 4k lands in lane 0 of word k
   for (genvar i = 0; i < 4; i++) begin : g_lane
      logic [7:0] mem [DEPTH_WORDS];
      logic       lane_we;

      assign lane_we = wr_en && (wr_addr[1:0] == 2'(i));

      always_ff @(posedge RX_CLK) begin
         if (lane_we) begin
            mem[wr_addr[10:2]] <= wr_data;
         end
      end

      // registered read of the whole word
      always_ff @(posedge RX_CLK) begin
         rd_data[8*i +: 8] <= mem[rd_addr];
      end
   end

endmodule

// ==== eth_rx_consts.svh ====
`ifndef ETH_RX_CONSTS_SVH
`define ETH_RX_CONSTS_SVH

// station address and framing
`define ETH_MAC_ADDR    48'h02_00_00_00_00_01
`define ETH_SFD         8'hD5
`define MAC_ADDR_LEN    6
`define ETH_HDR_LEN     14
`define ETH_FCS_LEN     4

// register value after a good frame, FCS included
`define ETH_CRC_RESIDUE 32'hDEBB20E3

`define BUF_BYTES       2048

// word addresses on the bus
`define REG_STATUS      12'h000
`define REG_NBYTES      12'h001
`define REG_CTRL        12'h002
`define BUF_SEL_BIT     11

`endif

// ==== eth_rx_frame.sv ====
`include "eth_rx_consts.svh"

module eth_rx_frame #(
   parameter logic [47:0] STATION_ADDR = `ETH_MAC_ADDR
) (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  RX_DV,
   input  eth_rx_pkg::nibble_t   RX_DATA,
   input  eth_rx_pkg::buf_addr_t nbytes,
   input  logic                  frame_release,
   output logic                  wr_en,
   output eth_rx_pkg::buf_addr_t wr_addr,
   output eth_rx_pkg::byte_t     wr_data,
   output logic                  crc_start,
   output logic                  frame_ready
);
   import eth_rx_pkg::*;

   rx_state_t   state;
   byte_t       shreg;
   byte_t       nib_byte;
   buf_addr_t   byte_cnt;
   buf_addr_t   frame_end;
   logic [47:0] dest_addr;
   logic        idle_seen;

   // byte formed if the current nibble is the high one
   assign nib_byte  = {RX_DATA, shreg[7:4]};
   assign frame_end = nbytes + buf_addr_t'(`ETH_HDR_LEN + `ETH_FCS_LEN);
   assign crc_start = (state == hunt);

   always_ff @(posedge RX_CLK) begin
      if (RX_DV) begin
         shreg <= nib_byte;
      end
      if (RX_DV && (state == dest || state == body)) begin
         wr_data <= nib_byte;
         wr_addr <= byte_cnt;
      end
      if (RX_DV && state == dest) begin
         dest_addr <= {dest_addr[39:0], nib_byte};
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state       <= hunt;
         byte_cnt    <= '0;
         wr_en       <= 1'b0;
         frame_ready <= 1'b0;
         idle_seen   <= 1'b0;
      end else begin
         wr_en <= 1'b0;

         // only start after a gap, so payload bytes never look like a delimiter
         if (!RX_DV) begin
            idle_seen <= 1'b1;
         end else if (state != hunt) begin
            idle_seen <= 1'b0;
         end

         case (state)
            hunt: begin
               if (RX_DV && idle_seen && nib_byte == `ETH_SFD) begin
                  state <= clear;
               end
            end
            clear: begin
               byte_cnt <= '0;
               state    <= RX_DV ? dest : hunt;
            end
            dest: begin
               if (RX_DV) begin
                  wr_en    <= 1'b1;
                  byte_cnt <= byte_cnt + 1'b1;
                  state    <= dest_chk;
               end else begin
                  state <= hunt;
               end
            end
            dest_chk: begin
               if (byte_cnt != buf_addr_t'(`MAC_ADDR_LEN)) begin
                  state <= RX_DV ? dest : hunt;
               end else if (dest_addr != STATION_ADDR) begin
                  // not for us
                  state <= hunt;
               end else begin
                  state <= RX_DV ? body : hunt;
               end
            end
            body: begin
               if (RX_DV) begin
                  wr_en    <= 1'b1;
                  byte_cnt <= byte_cnt + 1'b1;
                  state    <= body_chk;
               end else begin
                  state <= hunt;
               end
            end
            body_chk: begin
               if (byte_cnt == frame_end) begin
                  state       <= hold;
                  frame_ready <= 1'b1;
               end else begin
                  state <= RX_DV ? body : hunt;
               end
            end
            hold: begin
               if (frame_release) begin
                  state       <= hunt;
                  frame_ready <= 1'b0;
               end
            end
            default: state <= hunt;
         endcase
      end
   end

endmodule

// ==== eth_rx_pkg.sv ====
package eth_rx_pkg;

   typedef logic [7:0]  byte_t;
   typedef logic [3:0]  nibble_t;

   // byte address into the frame buffer
   typedef logic [10:0] buf_addr_t;

   typedef logic [31:0] crc_t;
   typedef logic [31:0] wb_word_t;

   // receive engine states
   typedef enum logic [2:0] {
      hunt,
      clear,
      dest,
      dest_chk,
      body,
      body_chk,
      hold
   } rx_state_t;

endpackage

// ==== eth_rx_top.sv ====
`include "eth_rx_consts.svh"

module eth_rx_top (
   input  logic                 RX_CLK,
   input  logic                 rx_rst,
   input  logic                 RX_DV,
   input  eth_rx_pkg::nibble_t  RX_DATA,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [11:0]          wb_adr,
   input  eth_rx_pkg::wb_word_t wb_dat_w,
   input  logic [3:0]           wb_sel,
   output eth_rx_pkg::wb_word_t wb_dat_r,
   output logic                 wb_ack
);
   import eth_rx_pkg::*;

   logic        wr_en;
   buf_addr_t   wr_addr;
   byte_t       wr_data;
   logic        crc_start;
   logic        frame_ready;
   logic        frame_release;
   crc_t        crc_value;
   buf_addr_t   nbytes;
   logic [8:0]  rd_addr;
   logic [31:0] rd_data;

   eth_rx_frame u_frame (
      .RX_CLK(RX_CLK), .rx_rst(rx_rst), .RX_DV(RX_DV), .RX_DATA(RX_DATA),
      .nbytes(nbytes), .frame_release(frame_release),
      .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .crc_start(crc_start), .frame_ready(frame_ready)
   );

   eth_crc u_crc (
      .RX_CLK(RX_CLK), .rx_rst(rx_rst), .start(crc_start),
      .data_en(wr_en), .data_in(wr_data), .crc_value(crc_value)
   );

   eth_rx_buffer #(.DEPTH_WORDS(`BUF_BYTES / 4)) u_buffer (
      .RX_CLK(RX_CLK), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
      .rd_addr(rd_addr), .rd_data(rd_data)
   );

   eth_rx_wb u_wb (
      .RX_CLK(RX_CLK), .rx_rst(rx_rst),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .frame_ready(frame_ready), .crc_value(crc_value), .nbytes(nbytes),
      .frame_release(frame_release), .rd_addr(rd_addr), .rd_data(rd_data)
   );

endmodule

// ==== eth_rx_wb.sv ====
`include "eth_rx_consts.svh"

module eth_rx_wb (
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  wb_cyc,
   input  logic                  wb_stb,
   input  logic                  wb_we,
   input  logic [11:0]           wb_adr,
   input  eth_rx_pkg::wb_word_t  wb_dat_w,
   input  logic [3:0]            wb_sel,
   output eth_rx_pkg::wb_word_t  wb_dat_r,
   output logic                  wb_ack,
   input  logic                  frame_ready,
   input  eth_rx_pkg::crc_t      crc_value,
   output eth_rx_pkg::buf_addr_t nbytes,
   output logic                  frame_release,
   output logic [8:0]            rd_addr,
   input  logic [31:0]           rd_data
);
   import eth_rx_pkg::*;

   logic     req;
   logic     buf_sel;
   logic     buf_rd;
   logic     reg_wr;
   logic     rd_pend;
   logic     crc_ok;
   wb_word_t rd_mux;

   // a transfer is live until its ack goes out
   assign req     = wb_cyc && wb_stb && !wb_ack;
   assign buf_sel = wb_adr[`BUF_SEL_BIT];
   assign buf_rd  = req && buf_sel && !wb_we;
   assign reg_wr  = req && !buf_sel && wb_we;
   assign rd_addr = wb_adr[8:0];
   assign crc_ok  = frame_ready && (crc_value == `ETH_CRC_RESIDUE);

   always_comb begin
      rd_mux = '0;
      if (buf_sel) begin
         rd_mux = rd_data;
      end else begin
         case (wb_adr)
            `REG_STATUS: rd_mux = {30'b0, crc_ok, frame_ready};
            `REG_NBYTES: rd_mux = {21'b0, nbytes};
            default:     rd_mux = '0;
         endcase
      end
   end

   // buffer reads wait one extra cycle for the memory output register
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         wb_ack  <= 1'b0;
         rd_pend <= 1'b0;
      end else begin
         wb_ack  <= 1'b0;
         rd_pend <= 1'b0;
         if (rd_pend) begin
            wb_ack <= 1'b1;
         end else if (buf_rd) begin
            rd_pend <= 1'b1;
         end else if (req) begin
            wb_ack <= 1'b1;
         end
      end
   end

   always_ff @(posedge RX_CLK) begin
      if (rd_pend || (req && !buf_rd)) begin
         wb_dat_r <= rd_mux;
      end
   end

   // length register and release strobe
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         nbytes        <= '0;
         frame_release <= 1'b0;
      end else begin
         frame_release <= 1'b0;
         if (reg_wr && wb_adr == `REG_NBYTES) begin
            if (wb_sel[0]) begin
               nbytes[7:0] <= wb_dat_w[7:0];
            end
            if (wb_sel[1]) begin
               nbytes[10:8] <= wb_dat_w[10:8];
            end
         end
         if (reg_wr && wb_adr == `REG_CTRL && wb_sel[0]) begin
            frame_release <= wb_dat_w[0];
         end
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tb_eth_rx -o sim_eth_rx \
   || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_eth_rx > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

// ==== tb_eth_rx.sv ====
`include "eth_rx_consts.svh"

module tb_eth_rx;
   timeunit 1ns;
   timeprecision 1ps;
   import eth_rx_pkg::*;

   localparam logic [47:0] other_addr = 48'h02_00_00_00_00_02;
   localparam logic [47:0] src_addr = 48'h02_00_00_00_00_99;
   // ten frames of at most 200 payload bytes plus preamble and gap
   localparam int frame_count = 10;
   localparam int max_frame_bytes = 8 + `ETH_HDR_LEN + 200 + `ETH_FCS_LEN + 6;
   localparam int watchdog_cycles = frame_count * max_frame_bytes * 2 + 20000;

   logic     RX_CLK;
   logic     rx_rst;
   logic     RX_DV;
   nibble_t  RX_DATA;
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   logic     [11:0] wb_adr;
   wb_word_t wb_dat_w;
   logic     [3:0] wb_sel;
   wb_word_t wb_dat_r;
   logic     wb_ack;
   byte_t    frame_q[$];
   byte_t    held_q[$];

   eth_rx_top uut (
      .RX_CLK(RX_CLK), .rx_rst(rx_rst), .RX_DV(RX_DV), .RX_DATA(RX_DATA),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #5 RX_CLK = ~RX_CLK;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge RX_CLK);
      $display("watchdog expired after %0d cycles, the run is stuck", watchdog_cycles);
      abort_run();
   end

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got,
                        input logic [31:0] expected);
      if (got !== expected) begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
         abort_run();
      end
   endtask

   // reflected CRC-32 over the first count bytes before the final inversion
   function automatic logic [31:0] crc32_ref(input int count);
      logic [31:0] crc;
      crc = 32'hFFFFFFFF;
      for (int i = 0; i < count; i++) begin
         crc = crc ^ {24'h0, frame_q[i]};
         for (int b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
         end
      end
      return crc;
   endfunction

   task automatic build_frame(input logic [47:0] dest, input int len);
      logic [31:0] fcs;
      frame_q.delete();
      for (int i = 5; i >= 0; i--) frame_q.push_back(dest[8*i +: 8]);
      for (int i = 5; i >= 0; i--) frame_q.push_back(src_addr[8*i +: 8]);
      frame_q.push_back(8'h88);
      frame_q.push_back(8'hB5);
      for (int i = 0; i < len; i++) frame_q.push_back(byte_t'($urandom));
      // fcs goes out inverted and low byte first
      fcs = ~crc32_ref(frame_q.size());
      for (int i = 0; i < 4; i++) frame_q.push_back(fcs[8*i +: 8]);
   endtask

   task automatic send_byte(input byte_t b);
      @(posedge RX_CLK);
      RX_DV   <= 1'b1;
      RX_DATA <= b[3:0];
      @(posedge RX_CLK);
      RX_DATA <= b[7:4];
   endtask

   task automatic send_frame();
      for (int i = 0; i < 7; i++) send_byte(8'h55);
      send_byte(`ETH_SFD);
      foreach (frame_q[i]) send_byte(frame_q[i]);
      @(posedge RX_CLK);
      RX_DV   <= 1'b0;
      RX_DATA <= '0;
      repeat (11) @(posedge RX_CLK);
   endtask

   task automatic bus_cycle(input logic [11:0] addr, input logic we,
                            input wb_word_t wdata, output wb_word_t rdata);
      int n;
      n = 0;
      @(posedge RX_CLK);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= addr;
      wb_dat_w <= wdata;
      wb_sel   <= 4'hF;
      do begin
         @(negedge RX_CLK);
         n++;
         if (n > 16) begin
            $display("bus access to address %h was never acknowledged", addr);
            abort_run();
         end
      end while (!wb_ack);
      rdata = wb_dat_r;
      @(posedge RX_CLK);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_read(input logic [11:0] addr, output wb_word_t data);
      bus_cycle(addr, 1'b0, '0, data);
   endtask

   task automatic wb_write(input logic [11:0] addr, input wb_word_t data);
      wb_word_t unused;
      bus_cycle(addr, 1'b1, data, unused);
   endtask

   task automatic wait_ready(output wb_word_t status);
      int polls;
      polls = 0;
      status = '0;
      while (!status[0]) begin
         wb_read(`REG_STATUS, status);
         polls++;
         if (!status[0] && polls >= 100) begin
            $display("frame_ready did not rise within 100 status reads");
            abort_run();
         end
      end
   endtask

   // every stored byte including the fcs in lane order
   task automatic compare_buffer();
      wb_word_t word;
      wb_word_t expected;
      wb_word_t mask;
      for (int k = 0; k < (frame_q.size() + 3) / 4; k++) begin
         wb_read((12'(1) << `BUF_SEL_BIT) | 12'(k), word);
         expected = '0;
         mask = '0;
         for (int l = 0; l < 4; l++) begin
            if (4 * k + l < frame_q.size()) begin
               expected[8*l +: 8] = frame_q[4*k + l];
               mask[8*l +: 8] = 8'hFF;
            end
         end
         check($sformatf("buffer word %0d", k), word & mask, expected);
      end
   endtask

   task automatic accept_frame(input int len);
      wb_word_t status;
      wb_write(`REG_NBYTES, wb_word_t'(len));
      build_frame(`ETH_MAC_ADDR, len);
      send_frame();
      wait_ready(status);
      check("status", status, 32'h3);
      compare_buffer();
   endtask

   task automatic release_frame();
      wb_word_t status;
      wb_write(`REG_CTRL, 32'h1);
      wb_read(`REG_STATUS, status);
      check("status after release", status, 32'h0);
   endtask

   task automatic read_reset_state();
      wb_word_t data;
      wb_read(`REG_STATUS, data);
      check("status", data, 32'h0);
      wb_read(`REG_NBYTES, data);
      check("nbytes", data, 32'h0);
      wb_read(12'(1) << `BUF_SEL_BIT, data);
   endtask

   task automatic receive_good_frame();
      int len;
      wb_word_t data;
      len = 46 + int'($urandom % 155);
      accept_frame(len);
      wb_read(`REG_NBYTES, data);
      check("nbytes", data, wb_word_t'(len));
      release_frame();
   endtask

   // reuses the frame left by receive_good_frame
   task automatic receive_bad_crc();
      wb_word_t status;
      frame_q[`ETH_HDR_LEN + 5] = frame_q[`ETH_HDR_LEN + 5] ^ 8'h10;
      send_frame();
      wait_ready(status);
      check("status with bad crc", status, 32'h1);
      compare_buffer();
      release_frame();
   endtask

   task automatic drop_foreign_frame();
      wb_word_t status;
      // length set to match so only the address filter can drop it
      wb_write(`REG_NBYTES, 32'd60);
      build_frame(other_addr, 60);
      send_frame();
      wb_read(`REG_STATUS, status);
      check("status after foreign frame", status, 32'h0);
      accept_frame(46 + int'($urandom % 155));
      release_frame();
   endtask

   task automatic drop_frame_while_held();
      wb_word_t status;
      accept_frame(64 + int'($urandom % 64));
      held_q = frame_q;
      build_frame(`ETH_MAC_ADDR, 80);
      send_frame();
      frame_q = held_q;
      wb_read(`REG_STATUS, status);
      check("status while held", status, 32'h3);
      compare_buffer();
      release_frame();
      accept_frame(46 + int'($urandom % 155));
      release_frame();
   endtask

   task automatic receive_back_to_back();
      accept_frame(46);
      release_frame();
      accept_frame(60 + int'($urandom % 40));
      release_frame();
      accept_frame(150 + int'($urandom % 51));
      release_frame();
   endtask

   initial begin
      rx_rst   <= 1'b1;
      RX_DV    <= 1'b0;
      RX_DATA  <= '0;
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      wb_adr   <= '0;
      wb_dat_w <= '0;
      wb_sel   <= '0;
      void'($urandom(81559));
      repeat (10) @(posedge RX_CLK);
      rx_rst <= 1'b0;
      read_reset_state();
      receive_good_frame();
      receive_bad_crc();
      drop_foreign_frame();
      drop_frame_while_held();
      receive_back_to_back();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+.
eth_rx_pkg.sv
eth_crc.sv
eth_rx_frame.sv
eth_rx_buffer.sv
eth_rx_wb.sv
eth_rx_top.sv
tb_eth_rx.sv
